// File: ipv4_ttl_engine.f
+incdir+.
ipv4_ttl_pkg.sv
ipv4_header_capture.sv
ipv4_checksum_check.sv
ipv4_ttl_update.sv
ipv4_forward_out.sv
ipv4_ttl_engine.sv
ipv4_ttl_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IPv4 TTL engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ipv4_ttl_engine_tb \
    -f ipv4_ttl_engine.f

if ./obj_dir/Vipv4_ttl_engine_tb | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// File: ipv4_ttl_engine_tb.sv
/* Directed testbench for the IPv4 TTL engine with reference model,
   compare tasks and watchdog */

`timescale 1ns/1ps

`include "ipv4_ttl_params.svh"

module ipv4_ttl_engine_tb;

    import ipv4_ttl_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int BURST_LEN   = 50;
    // Reset, idle watch, six single headers, then the burst and its drain
    localparam int TEST_CYCLES = 4 + 8 + 6 * (`ENGINE_LATENCY + 2) + BURST_LEN +
                                 `ENGINE_LATENCY + 2;

    logic         core_clk_ifc;
    logic         reset;
    logic         in_valid;
    ipv4_header_t in_header;
    logic         out_valid;
    ipv4_header_t out_header;
    logic         out_forward;
    drop_reason_t out_reason;
    int           errors;

    ipv4_ttl_engine dut (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_header    (in_header),
        .out_valid    (out_valid),
        .out_header   (out_header),
        .out_forward  (out_forward),
        .out_reason   (out_reason)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // End-around carry fold of a wide sum
    function automatic logic [15:0] fold16(input logic [31:0] sum);
        logic [31:0] s;
        s = 32'(sum[15:0]) + 32'(sum[31:16]);
        s = 32'(s[15:0]) + 32'(s[31:16]);
        return s[15:0];
    endfunction

    function automatic logic [15:0] header_sum(input ipv4_header_t h);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            acc = acc + 32'(h.words[i]);
        end
        return fold16(acc);
    endfunction

    // Random fields with the checksum computed from scratch
    function automatic ipv4_header_t make_header(input logic [3:0] version,
                                                 input logic [3:0] ihl,
                                                 input logic [7:0] ttl);
        ipv4_header_t h;
        h = {$urandom, $urandom, $urandom, $urandom, $urandom};
        h.fields.version = version;
        h.fields.ihl     = ihl;
        h.fields.ttl     = ttl;
        h.fields.hdr_chk = 16'h0000;
        h.fields.hdr_chk = ~header_sum(h);
        return h;
    endfunction

    function automatic drop_reason_t expect_reason(input ipv4_header_t h);
        if (h.fields.version != `IPV4_VERSION || h.fields.ihl != `IPV4_IHL) begin
            return drop_bad_format;
        end
        if (header_sum(h) != 16'hffff) begin
            return drop_bad_checksum;
        end
        if (h.fields.ttl <= `TTL_EXPIRE_LIMIT) begin
            return drop_ttl_expired;
        end
        return drop_none;
    endfunction

    // The TTL patch keeps the one's-complement sum of the whole header
    function automatic ipv4_header_t expect_header(input ipv4_header_t h);
        ipv4_header_t n;
        logic [15:0]  old_err;
        if (h.fields.ttl <= `TTL_EXPIRE_LIMIT) begin
            return h;
        end
        // Zero for a header whose checksum was good
        old_err          = ~header_sum(h);
        n                = h;
        n.fields.ttl     = h.fields.ttl - 8'd1;
        n.fields.hdr_chk = 16'h0000;
        // Full recomputation over the new header, carrying any old error along
        n.fields.hdr_chk = ~fold16(32'(header_sum(n)) + 32'(old_err));
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_header(input string name, input ipv4_header_t got,
                                input ipv4_header_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reason(input string name, input drop_reason_t got,
                                input drop_reason_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %s (%b), expected %s", $time, name,
                     got.name(), got, exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic run_single(input ipv4_header_t h, input drop_reason_t exp_reason);
        int cycles;
        cycles = 0;
        @(negedge core_clk_ifc);
        in_valid  = 1'b1;
        in_header = h;
        do begin
            @(negedge core_clk_ifc);
            in_valid = 1'b0;
            cycles++;
        end while (!out_valid && cycles < 4 * `ENGINE_LATENCY);
        if (!out_valid) begin
            errors++;
            $display("No out_valid within %0d cycles of the input pulse", cycles);
        end else begin
            if (cycles != `ENGINE_LATENCY) begin
                errors++;
                $display("out_valid came after %0d cycles instead of %0d", cycles,
                         `ENGINE_LATENCY);
            end
            check_header("out_header", out_header, expect_header(h));
            check_reason("out_reason", out_reason, exp_reason);
            check_bit("out_forward", out_forward, exp_reason == drop_none);
        end
    endtask

    task automatic test_idle();
        repeat (8) begin
            @(negedge core_clk_ifc);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("out_forward", out_forward, 1'b0);
        end
    endtask

    task automatic test_forward();
        run_single(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd64), drop_none);
    endtask

    task automatic test_ttl_expiry();
        run_single(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd1), drop_ttl_expired);
        run_single(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd0), drop_ttl_expired);
    endtask

    // Format faults also carry a bad checksum to show the priority
    task automatic test_drops();
        ipv4_header_t h;
        h = make_header(`IPV4_VERSION, `IPV4_IHL, 8'd64);
        h.fields.hdr_chk = h.fields.hdr_chk ^ 16'h0101;
        run_single(h, drop_bad_checksum);
        h = make_header(4'd6, `IPV4_IHL, 8'd64);
        h.fields.hdr_chk = h.fields.hdr_chk ^ 16'h0101;
        run_single(h, drop_bad_format);
        h = make_header(`IPV4_VERSION, 4'd6, 8'd64);
        h.fields.hdr_chk = h.fields.hdr_chk ^ 16'h0101;
        run_single(h, drop_bad_format);
    endtask

    task automatic test_burst();
        ipv4_header_t exp_q[$];
        ipv4_header_t h;
        ipv4_header_t exp_h;
        logic [3:0]   version;
        int           sent;
        int           cycles;
        sent   = 0;
        cycles = 0;
        while ((sent < BURST_LEN || exp_q.size() > 0) && cycles < BURST_LEN + 10) begin
            @(negedge core_clk_ifc);
            cycles++;
            if (out_valid && exp_q.size() == 0) begin
                errors++;
                $display("out_valid at %0t with no header outstanding", $time);
            end else if (out_valid) begin
                h     = exp_q.pop_front();
                exp_h = expect_header(h);
                check_header("out_header", out_header, exp_h);
                check_reason("out_reason", out_reason, expect_reason(h));
                check_bit("out_forward", out_forward, expect_reason(h) == drop_none);
            end
            if (sent < BURST_LEN) begin
                version = ($urandom % 8 == 0) ? 4'd6 : `IPV4_VERSION;
                h = make_header(version, `IPV4_IHL, 8'($urandom));
                if ($urandom % 4 == 0) begin
                    h.fields.hdr_chk = h.fields.hdr_chk ^ 16'($urandom % 32'hffff + 1);
                end
                in_valid  = 1'b1;
                in_header = h;
                exp_q.push_back(h);
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d burst headers never came out", exp_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        errors    = 0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_header = '0;
        void'($urandom(32'hc25a455d));
        repeat (4) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        reset = 1'b0;
        test_idle();
        test_forward();
        test_ttl_expiry();
        test_drops();
        test_burst();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: ipv4_ttl_engine.sv
/* IPv4 forwarding header engine top: capture, check, update, output */

`timescale 1ns/1ps

`include "ipv4_ttl_params.svh"

module ipv4_ttl_engine (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       in_valid,
    input  ipv4_ttl_pkg::ipv4_header_t in_header,
    output logic                       out_valid,
    output ipv4_ttl_pkg::ipv4_header_t out_header,
    output logic                       out_forward,
    output ipv4_ttl_pkg::drop_reason_t out_reason
);

    import ipv4_ttl_pkg::*;

    logic         cap_valid;
    ipv4_header_t cap_header;
    logic         cap_format_ok;
    logic         chk_valid;
    logic         chk_ok;
    logic         chk_format_ok;
    ipv4_header_t upd_header;
    logic         upd_expired;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    ipv4_header_capture u_capture (
        .core_clk_ifc  (core_clk_ifc),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_header     (in_header),
        .cap_valid     (cap_valid),
        .cap_header    (cap_header),
        .cap_format_ok (cap_format_ok)
    );

    // Check and update run side by side on the captured header
    ipv4_checksum_check u_check (
        .core_clk_ifc  (core_clk_ifc),
        .reset         (reset),
        .cap_valid     (cap_valid),
        .cap_header    (cap_header),
        .cap_format_ok (cap_format_ok),
        .chk_valid     (chk_valid),
        .chk_ok        (chk_ok),
        .chk_format_ok (chk_format_ok)
    );

    ipv4_ttl_update u_update (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .cap_valid    (cap_valid),
        .cap_header   (cap_header),
        .upd_header   (upd_header),
        .upd_expired  (upd_expired)
    );

    ipv4_forward_out u_out (
        .core_clk_ifc  (core_clk_ifc),
        .reset         (reset),
        .chk_valid     (chk_valid),
        .chk_ok        (chk_ok),
        .chk_format_ok (chk_format_ok),
        .upd_header    (upd_header),
        .upd_expired   (upd_expired),
        .out_valid     (out_valid),
        .out_header    (out_header),
        .out_forward   (out_forward),
        .out_reason    (out_reason)
    );

    // Fixed latency through all three register stages
    a_latency: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        in_valid |-> ##`ENGINE_LATENCY out_valid
    ) else $error("out_valid missing after input pulse");

endmodule

// File: ipv4_forward_out.sv
/* Output stage: prioritized drop reason and forward decision register */

`timescale 1ns/1ps

module ipv4_forward_out (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       chk_valid,
    input  logic                       chk_ok,
    input  logic                       chk_format_ok,
    input  ipv4_ttl_pkg::ipv4_header_t upd_header,
    input  logic                       upd_expired,
    output logic                       out_valid,
    output ipv4_ttl_pkg::ipv4_header_t out_header,
    output logic                       out_forward,
    output ipv4_ttl_pkg::drop_reason_t out_reason
);

    import ipv4_ttl_pkg::*;

    drop_reason_t reason;

    // Format first, then checksum, then TTL
    always_comb begin
        if (!chk_format_ok) begin
            reason = drop_bad_format;
        end else if (!chk_ok) begin
            reason = drop_bad_checksum;
        end else if (upd_expired) begin
            reason = drop_ttl_expired;
        end else begin
            reason = drop_none;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decision registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            out_valid   <= 1'b0;
            out_forward <= 1'b0;
        end else begin
            out_valid <= chk_valid;
            if (chk_valid) begin
                out_forward <= (reason == drop_none);
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (chk_valid) begin
            out_reason <= reason;
            out_header <= upd_header;
        end
    end

    a_forward_clean: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        out_forward |-> out_reason == drop_none
    ) else $error("forwarded packet carries a drop reason");

endmodule

// File: ipv4_ttl_update.sv
/* TTL decrement with incremental checksum patch and TTL expiry test */

`timescale 1ns/1ps

`include "ipv4_ttl_params.svh"

module ipv4_ttl_update (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       cap_valid,
    input  ipv4_ttl_pkg::ipv4_header_t cap_header,
    output ipv4_ttl_pkg::ipv4_header_t upd_header,
    output logic                       upd_expired
);

    import ipv4_ttl_pkg::*;

    // Word holding ttl in the high byte and protocol in the low byte
    localparam int TTL_PROTO_WORD = 5;

    logic         expired;
    logic [7:0]   new_ttl;
    logic [15:0]  new_word;
    logic [17:0]  patch_sum;
    logic [16:0]  patch_once;
    logic [15:0]  patch_twice;
    ipv4_header_t next_header;

    ////////////////////////////////////////////////////////////
    // Incremental checksum HC' = ~(~HC + ~m + m')
    ////////////////////////////////////////////////////////////

    always_comb begin
        expired  = (cap_header.fields.ttl <= `TTL_EXPIRE_LIMIT);
        new_ttl  = cap_header.fields.ttl - 8'd1;
        new_word = {new_ttl, cap_header.fields.protocol};

        patch_sum = {2'b00, ~cap_header.fields.hdr_chk} +
                    {2'b00, ~cap_header.words[TTL_PROTO_WORD]} +
                    18'(new_word);
        patch_once  = 17'(patch_sum[15:0]) + 17'(patch_sum[17:16]);
        patch_twice = patch_once[15:0] + 16'(patch_once[16]);

        // Expired headers leave untouched
        next_header = cap_header;
        if (!expired) begin
            next_header.fields.ttl     = new_ttl;
            next_header.fields.hdr_chk = ~patch_twice;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers aligned with chk_valid
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            upd_expired <= 1'b0;
        end else if (cap_valid) begin
            upd_expired <= expired;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (cap_valid) begin
            upd_header <= next_header;
        end
    end

    // Forwarded header leaves with exactly one hop less
    a_ttl_decrement: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        cap_valid && !expired |=>
            upd_header.fields.ttl == $past(cap_header.fields.ttl) - 8'd1
    ) else $error("forwarded TTL not decremented by one");

endmodule

// File: ipv4_checksum_check.sv
/* Header checksum verification by one's-complement sum of all ten words */

`timescale 1ns/1ps

`include "ipv4_ttl_params.svh"

module ipv4_checksum_check (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       cap_valid,
    input  ipv4_ttl_pkg::ipv4_header_t cap_header,
    input  logic                       cap_format_ok,
    output logic                       chk_valid,
    output logic                       chk_ok,
    output logic                       chk_format_ok
);

    // Room for the carries of all words before folding
    localparam int SUM_W = 16 + $clog2(`IPV4_HDR_WORDS);

    logic [SUM_W-1:0] word_sum;
    logic [16:0]      fold_once;
    logic [15:0]      fold_twice;
    logic             sum_ok;

    ////////////////////////////////////////////////////////////
    // One's-complement sum
    ////////////////////////////////////////////////////////////

    always_comb begin
        word_sum = '0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            word_sum = word_sum + SUM_W'(cap_header.words[i]);
        end
        // End-around carry, second fold catches the carry of the first
        fold_once  = 17'(word_sum[15:0]) + 17'(word_sum[SUM_W-1:16]);
        fold_twice = fold_once[15:0] + 16'(fold_once[16]);
    end

    // A correct header including its checksum sums to all ones
    assign sum_ok = (fold_twice == 16'hffff);

    ////////////////////////////////////////////////////////////
    // Result registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= cap_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (cap_valid) begin
            chk_ok        <= sum_ok;
            chk_format_ok <= cap_format_ok;
        end
    end

endmodule

// File: ipv4_header_capture.sv
/* Input register stage with version and IHL check */

`timescale 1ns/1ps

`include "ipv4_ttl_params.svh"

module ipv4_header_capture (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       in_valid,
    input  ipv4_ttl_pkg::ipv4_header_t in_header,
    output logic                       cap_valid,
    output ipv4_ttl_pkg::ipv4_header_t cap_header,
    output logic                       cap_format_ok
);

    logic format_ok;

    // Only plain 20-byte IPv4 headers are handled
    assign format_ok = (in_header.fields.version == `IPV4_VERSION) &&
                       (in_header.fields.ihl == `IPV4_IHL);

    ////////////////////////////////////////////////////////////
    // Capture registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= in_valid;
        end
    end

    // Header and flag only move on a new pulse
    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            cap_header    <= in_header;
            cap_format_ok <= format_ok;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // An X on the pulse would corrupt every stage downstream
    a_in_valid_known: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        !$isunknown(in_valid)
    ) else $error("in_valid is unknown");

endmodule

// File: ipv4_ttl_pkg.sv
/* Header field struct, field/word union and drop reason enum */

`include "ipv4_ttl_params.svh"

package ipv4_ttl_pkg;

    ////////////////////////////////////////////////////////////
    // Header layout
    ////////////////////////////////////////////////////////////

    // Network order, version sits in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_chk;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_header_fields_t;

    // Word view for checksum arithmetic
    // words[9] holds version/ihl/tos, words[5] ttl/protocol, words[4] hdr_chk
    typedef union packed {
        ipv4_header_fields_t                fields;
        logic [`IPV4_HDR_WORDS-1:0][15:0]   words;
    } ipv4_header_t;

    ////////////////////////////////////////////////////////////
    // Forwarding result
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        drop_none         = 2'd0,
        drop_bad_format   = 2'd1,
        drop_bad_checksum = 2'd2,
        drop_ttl_expired  = 2'd3
    } drop_reason_t;

endpackage

// File: ipv4_ttl_params.svh
/* Header geometry, expected IPv4 field values and pipeline latency */

`ifndef IPV4_TTL_PARAMS_SVH
`define IPV4_TTL_PARAMS_SVH

////////////////////////////////////////////////////////////
// Header geometry
////////////////////////////////////////////////////////////

`define IPV4_HDR_BYTES 20
// 16-bit words covered by the checksum
`define IPV4_HDR_WORDS (`IPV4_HDR_BYTES / 2)

////////////////////////////////////////////////////////////
// Field values
////////////////////////////////////////////////////////////

`define IPV4_VERSION 4'd4
// IHL counts 32-bit words, no options supported
`define IPV4_IHL 4'd5
// Largest TTL that must not be forwarded
`define TTL_EXPIRE_LIMIT 8'd1

// Input pulse to output pulse, in cycles
`define ENGINE_LATENCY 3

`endif
